/* common/ex_config.svh */
// datapath, register index, csr index and data memory size macros
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// datapath word
`define EX_WORD_WD        64

// register file and csr indices
`define EX_GPR_ADDR_WD    5
`define EX_CSR_ADDR_WD    12

// data sram request
`define EX_SRAM_ADDR_WD   32   // byte address
`define EX_SRAM_WMASK_WD  8    // one bit per byte lane

// data memory size in 64-bit words
// word index comes from address bits 10:3
`define EX_SRAM_DEPTH     256

`endif

/* common/ex_pkg.sv */
// opcode enums and stage bundle structs for the execute and memory stages
`include "ex_config.svh"

package ex_pkg;

  typedef enum logic [4:0] {
    ALU_ADD       = 5'd0,
    ALU_SUB       = 5'd1,
    ALU_SLL       = 5'd2,
    ALU_SLT       = 5'd3,
    ALU_SLTU      = 5'd4,
    ALU_XOR       = 5'd5,
    ALU_SRL       = 5'd6,
    ALU_SRA       = 5'd7,
    ALU_OR        = 5'd8,
    ALU_AND       = 5'd9,
    ALU_COPY_SRC2 = 5'd10   // lui style pass-through
  } alu_op_e;

  typedef enum logic [1:0] {
    SRC2_RS2  = 2'd0,
    SRC2_IMM  = 2'd1,
    SRC2_FOUR = 2'd2        // link address for jal/jalr
  } alu_src2_e;

  // funct3 coding
  typedef enum logic [2:0] {
    MEM_B  = 3'b000,
    MEM_H  = 3'b001,
    MEM_W  = 3'b010,
    MEM_D  = 3'b011,
    MEM_BU = 3'b100,
    MEM_HU = 3'b101,
    MEM_WU = 3'b110
  } mem_op_e;

  // funct3 coding, bit 2 marks the immediate forms
  typedef enum logic [2:0] {
    CSR_RW  = 3'b001,
    CSR_RS  = 3'b010,
    CSR_RC  = 3'b011,
    CSR_RWI = 3'b101,
    CSR_RSI = 3'b110,
    CSR_RCI = 3'b111
  } csr_op_e;

  // 359 bits, msb first
  typedef struct packed {
    logic [`EX_WORD_WD-1:0]     rs1data;
    logic [`EX_WORD_WD-1:0]     rs2data;
    logic [`EX_WORD_WD-1:0]     csrrdata;
    logic [`EX_WORD_WD-1:0]     imm;
    logic [`EX_WORD_WD-1:0]     pc;
    logic                       alu_src1_sel;     // 1: pc
    alu_src2_e                  alu_src2_sel;
    logic                       alu_word_cut_sel;
    alu_op_e                    alu_op;
    logic [`EX_GPR_ADDR_WD-1:0] rd;
    logic [`EX_CSR_ADDR_WD-1:0] csr;
    logic                       gpr_wen;
    logic                       csr_wen;
    logic                       mem_ren;
    logic                       mem_wen;
    mem_op_e                    mem_op;
    logic                       csr_inst_sel;     // csrrdata goes to rd
    csr_op_e                    csr_op;
    logic                       ebreak_sel;
    logic                       invalid_inst_sel;
  } ds_to_es_bus_t;

  typedef struct packed {
    logic [`EX_GPR_ADDR_WD-1:0] rd;
    logic [`EX_CSR_ADDR_WD-1:0] csr;
    logic [`EX_WORD_WD-1:0]     pc;
    logic                       gpr_wen;
    logic                       csr_wen;
    logic                       mem_ren;
    mem_op_e                    mem_op;
    logic                       csr_inst_sel;
    logic [`EX_WORD_WD-1:0]     csrrdata;
    logic [`EX_WORD_WD-1:0]     alu_result;
    logic [`EX_WORD_WD-1:0]     csr_result;
    logic                       ebreak;
    logic                       invalid;
  } es_to_ms_bus_t;

  typedef struct packed {
    logic [`EX_WORD_WD-1:0]     pc;
    logic [`EX_GPR_ADDR_WD-1:0] rd;
    logic                       gpr_wen;
    logic [`EX_WORD_WD-1:0]     gpr_wdata;
    logic [`EX_CSR_ADDR_WD-1:0] csr;
    logic                       csr_wen;
    logic [`EX_WORD_WD-1:0]     csr_wdata;
    logic                       ebreak;
    logic                       invalid;
  } ms_to_ws_bus_t;

  typedef struct packed {
    logic [`EX_SRAM_ADDR_WD-1:0]  addr;
    logic                         ren;
    logic                         wen;
    logic [`EX_SRAM_WMASK_WD-1:0] wmask;
    logic [`EX_WORD_WD-1:0]       wdata;
  } sram_req_t;

endpackage

/* ex/exu.sv */
// alu with operand select and word truncation, csr read-modify-write value
`include "ex_config.svh"

module exu (
  input  logic [`EX_WORD_WD-1:0] i_rs1data,
  input  logic [`EX_WORD_WD-1:0] i_rs2data,
  input  logic [`EX_WORD_WD-1:0] i_imm,
  input  logic [`EX_WORD_WD-1:0] i_pc,
  input  logic [`EX_WORD_WD-1:0] i_csrrdata,
  input  logic                   i_alu_src1_sel,
  input  ex_pkg::alu_src2_e      i_alu_src2_sel,
  input  ex_pkg::alu_op_e        i_alu_op,
  input  logic                   i_alu_word_cut_sel,
  input  ex_pkg::csr_op_e        i_csr_op,
  output logic [`EX_WORD_WD-1:0] o_alu_result,
  output logic [`EX_WORD_WD-1:0] o_csr_result
);

  localparam int SHAMT_WD = $clog2(`EX_WORD_WD);
  localparam int HALF_WD  = `EX_WORD_WD / 2;
  localparam logic [`EX_WORD_WD-1:0] CONST_FOUR = 4;

  logic [`EX_WORD_WD-1:0] src1;
  logic [`EX_WORD_WD-1:0] src2;
  logic [`EX_WORD_WD-1:0] shift_src;
  logic [SHAMT_WD-1:0]    shamt;
  logic [`EX_WORD_WD-1:0] alu_raw;
  logic [`EX_WORD_WD-1:0] csr_src;

  assign src1 = i_alu_src1_sel ? i_pc : i_rs1data;

  always_comb begin
    case (i_alu_src2_sel)
      ex_pkg::SRC2_RS2:  src2 = i_rs2data;
      ex_pkg::SRC2_IMM:  src2 = i_imm;
      ex_pkg::SRC2_FOUR: src2 = CONST_FOUR;
      default:           src2 = '0;
    endcase
  end

  // word ops shift the low half with a 5-bit amount
  assign shamt = i_alu_word_cut_sel ? {1'b0, src2[SHAMT_WD-2:0]} : src2[SHAMT_WD-1:0];

  always_comb begin
    if (!i_alu_word_cut_sel) begin
      shift_src = src1;
    end else if (i_alu_op == ex_pkg::ALU_SRA) begin
      shift_src = {{HALF_WD{src1[HALF_WD-1]}}, src1[HALF_WD-1:0]};   // sraw
    end else begin
      shift_src = {{HALF_WD{1'b0}}, src1[HALF_WD-1:0]};
    end
  end

  always_comb begin
    case (i_alu_op)
      ex_pkg::ALU_ADD:       alu_raw = src1 + src2;
      ex_pkg::ALU_SUB:       alu_raw = src1 - src2;
      ex_pkg::ALU_SLL:       alu_raw = shift_src << shamt;
      ex_pkg::ALU_SLT:       alu_raw = {{(`EX_WORD_WD-1){1'b0}}, $signed(src1) < $signed(src2)};
      ex_pkg::ALU_SLTU:      alu_raw = {{(`EX_WORD_WD-1){1'b0}}, src1 < src2};
      ex_pkg::ALU_XOR:       alu_raw = src1 ^ src2;
      ex_pkg::ALU_SRL:       alu_raw = shift_src >> shamt;
      ex_pkg::ALU_SRA:       alu_raw = $signed(shift_src) >>> shamt;
      ex_pkg::ALU_OR:        alu_raw = src1 | src2;
      ex_pkg::ALU_AND:       alu_raw = src1 & src2;
      ex_pkg::ALU_COPY_SRC2: alu_raw = src2;
      default:               alu_raw = '0;
    endcase
  end

  // addw/subw/sllw... sign extend bit 31
  assign o_alu_result = i_alu_word_cut_sel ?
                        {{HALF_WD{alu_raw[HALF_WD-1]}}, alu_raw[HALF_WD-1:0]} : alu_raw;

  // zimm arrives in imm for the immediate forms
  always_comb begin
    case (i_csr_op)
      ex_pkg::CSR_RWI,
      ex_pkg::CSR_RSI,
      ex_pkg::CSR_RCI: csr_src = i_imm;
      default:         csr_src = i_rs1data;
    endcase
  end

  always_comb begin
    case (i_csr_op)
      ex_pkg::CSR_RW,
      ex_pkg::CSR_RWI: o_csr_result = csr_src;
      ex_pkg::CSR_RS,
      ex_pkg::CSR_RSI: o_csr_result = i_csrrdata | csr_src;
      ex_pkg::CSR_RC,
      ex_pkg::CSR_RCI: o_csr_result = i_csrrdata & ~csr_src;
      default:         o_csr_result = i_csrrdata;   // no csr write
    endcase
  end

endmodule

/* ex/lsu_store.sv */
// store byte mask and lane-shifted store data
`include "ex_config.svh"

module lsu_store (
  input  ex_pkg::mem_op_e              i_mem_op,
  input  logic [2:0]                   i_waddr_align,
  input  logic [`EX_WORD_WD-1:0]       i_wdata,
  output logic [`EX_SRAM_WMASK_WD-1:0] o_wmask,
  output logic [`EX_WORD_WD-1:0]       o_wdata
);

  logic [`EX_SRAM_WMASK_WD-1:0] size_mask;
  logic [`EX_WORD_WD-1:0]       wdata_low;

  // mask and data at lane 0 by access size
  always_comb begin
    case (i_mem_op)
      ex_pkg::MEM_B,
      ex_pkg::MEM_BU: begin
        size_mask = 8'h01;
        wdata_low = {{(`EX_WORD_WD-8){1'b0}}, i_wdata[7:0]};
      end
      ex_pkg::MEM_H,
      ex_pkg::MEM_HU: begin
        size_mask = 8'h03;
        wdata_low = {{(`EX_WORD_WD-16){1'b0}}, i_wdata[15:0]};
      end
      ex_pkg::MEM_W,
      ex_pkg::MEM_WU: begin
        size_mask = 8'h0f;
        wdata_low = {{(`EX_WORD_WD-32){1'b0}}, i_wdata[31:0]};
      end
      default: begin   // sd
        size_mask = 8'hff;
        wdata_low = i_wdata;
      end
    endcase
  end

  // move to the addressed lane, address is size aligned
  assign o_wmask = size_mask << i_waddr_align;
  assign o_wdata = wdata_low << {i_waddr_align, 3'b000};

endmodule

/* ex/ex_stage.sv */
// execute stage: valid/allowin handshake, bundle register, alu/csr and data sram request
`include "ex_config.svh"

module ex_stage (
  input  logic                  i_clk,
  input  logic                  i_reset,
  // allowin
  input  logic                  i_ms_allowin,
  output logic                  o_es_allowin,
  // from decode
  input  logic                  i_ds_to_es_valid,
  input  ex_pkg::ds_to_es_bus_t i_ds_to_es_bus,
  // to memory stage
  output logic                  o_es_to_ms_valid,
  output ex_pkg::es_to_ms_bus_t o_es_to_ms_bus,
  // data sram
  output ex_pkg::sram_req_t     o_sram_req
);

  logic                   es_valid;
  logic                   es_ready_go;
  logic                   es_to_ms_fire;
  ex_pkg::ds_to_es_bus_t  es_bus_r;
  logic [`EX_WORD_WD-1:0] es_alu_result;
  logic [`EX_WORD_WD-1:0] es_csr_result;

  assign es_ready_go      = 1'b1;   // single cycle alu
  assign o_es_allowin     = !es_valid || (es_ready_go && i_ms_allowin);
  assign o_es_to_ms_valid = es_valid && es_ready_go;
  assign es_to_ms_fire    = o_es_to_ms_valid && i_ms_allowin;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      es_valid <= 1'b0;
    end else if (o_es_allowin) begin
      es_valid <= i_ds_to_es_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ds_to_es_valid && o_es_allowin) begin
      es_bus_r <= i_ds_to_es_bus;
    end
  end

  exu u_exu (
    .i_rs1data          (es_bus_r.rs1data),
    .i_rs2data          (es_bus_r.rs2data),
    .i_imm              (es_bus_r.imm),
    .i_pc               (es_bus_r.pc),
    .i_csrrdata         (es_bus_r.csrrdata),
    .i_alu_src1_sel     (es_bus_r.alu_src1_sel),
    .i_alu_src2_sel     (es_bus_r.alu_src2_sel),
    .i_alu_op           (es_bus_r.alu_op),
    .i_alu_word_cut_sel (es_bus_r.alu_word_cut_sel),
    .i_csr_op           (es_bus_r.csr_op),
    .o_alu_result       (es_alu_result),
    .o_csr_result       (es_csr_result)
  );

  lsu_store u_lsu_store (
    .i_mem_op      (es_bus_r.mem_op),
    .i_waddr_align (es_alu_result[2:0]),   // rs1 + imm
    .i_wdata       (es_bus_r.rs2data),
    .o_wmask       (o_sram_req.wmask),
    .o_wdata       (o_sram_req.wdata)
  );

  // only the transfer cycle touches the sram
  assign o_sram_req.addr = es_alu_result[`EX_SRAM_ADDR_WD-1:0];
  assign o_sram_req.ren  = es_bus_r.mem_ren && es_to_ms_fire;
  assign o_sram_req.wen  = es_bus_r.mem_wen && es_to_ms_fire;

  assign o_es_to_ms_bus.rd           = es_bus_r.rd;
  assign o_es_to_ms_bus.csr          = es_bus_r.csr;
  assign o_es_to_ms_bus.pc           = es_bus_r.pc;
  assign o_es_to_ms_bus.gpr_wen      = es_bus_r.gpr_wen;
  assign o_es_to_ms_bus.csr_wen      = es_bus_r.csr_wen;
  assign o_es_to_ms_bus.mem_ren      = es_bus_r.mem_ren;
  assign o_es_to_ms_bus.mem_op       = es_bus_r.mem_op;
  assign o_es_to_ms_bus.csr_inst_sel = es_bus_r.csr_inst_sel;
  assign o_es_to_ms_bus.csrrdata     = es_bus_r.csrrdata;
  assign o_es_to_ms_bus.alu_result   = es_alu_result;
  assign o_es_to_ms_bus.csr_result   = es_csr_result;
  assign o_es_to_ms_bus.ebreak       = es_bus_r.ebreak_sel;
  assign o_es_to_ms_bus.invalid      = es_bus_r.invalid_inst_sel;

endmodule

/* mem/mem_stage.sv */
// memory stage: bundle register, read-data hold, load extraction, write-back select
`include "ex_config.svh"

module mem_stage (
  input  logic                   i_clk,
  input  logic                   i_reset,
  input  logic                   i_es_to_ms_valid,
  input  ex_pkg::es_to_ms_bus_t  i_es_to_ms_bus,
  output logic                   o_ms_allowin,
  input  logic [`EX_WORD_WD-1:0] i_sram_rdata,
  input  logic                   i_ws_allowin,
  output logic                   o_ms_to_ws_valid,
  output ex_pkg::ms_to_ws_bus_t  o_ms_to_ws_bus
);

  logic                   ms_valid;
  logic                   ms_ready_go;
  logic                   ms_first;      // sram word arrives this cycle
  ex_pkg::es_to_ms_bus_t  ms_bus_r;
  logic [`EX_WORD_WD-1:0] rdata_hold;
  logic [`EX_WORD_WD-1:0] ms_rdata;
  logic [`EX_WORD_WD-1:0] load_shift;
  logic [`EX_WORD_WD-1:0] load_data;

  assign ms_ready_go      = 1'b1;   // read data is held locally
  assign o_ms_allowin     = !ms_valid || (ms_ready_go && i_ws_allowin);
  assign o_ms_to_ws_valid = ms_valid && ms_ready_go;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ms_valid <= 1'b0;
      ms_first <= 1'b0;
    end else begin
      if (o_ms_allowin) begin
        ms_valid <= i_es_to_ms_valid;
      end
      ms_first <= i_es_to_ms_valid && o_ms_allowin;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_es_to_ms_valid && o_ms_allowin) begin
      ms_bus_r <= i_es_to_ms_bus;
    end
    if (ms_first) begin
      rdata_hold <= i_sram_rdata;
    end
  end

  assign ms_rdata   = ms_first ? i_sram_rdata : rdata_hold;
  assign load_shift = ms_rdata >> {ms_bus_r.alu_result[2:0], 3'b000};

  always_comb begin
    case (ms_bus_r.mem_op)
      ex_pkg::MEM_B:  load_data = {{(`EX_WORD_WD-8){load_shift[7]}}, load_shift[7:0]};
      ex_pkg::MEM_H:  load_data = {{(`EX_WORD_WD-16){load_shift[15]}}, load_shift[15:0]};
      ex_pkg::MEM_W:  load_data = {{(`EX_WORD_WD-32){load_shift[31]}}, load_shift[31:0]};
      ex_pkg::MEM_BU: load_data = {{(`EX_WORD_WD-8){1'b0}}, load_shift[7:0]};
      ex_pkg::MEM_HU: load_data = {{(`EX_WORD_WD-16){1'b0}}, load_shift[15:0]};
      ex_pkg::MEM_WU: load_data = {{(`EX_WORD_WD-32){1'b0}}, load_shift[31:0]};
      default:        load_data = load_shift;   // ld
    endcase
  end

  assign o_ms_to_ws_bus.pc        = ms_bus_r.pc;
  assign o_ms_to_ws_bus.rd        = ms_bus_r.rd;
  assign o_ms_to_ws_bus.gpr_wen   = ms_bus_r.gpr_wen;
  assign o_ms_to_ws_bus.gpr_wdata = ms_bus_r.mem_ren      ? load_data :
                                    ms_bus_r.csr_inst_sel ? ms_bus_r.csrrdata :
                                                            ms_bus_r.alu_result;
  assign o_ms_to_ws_bus.csr       = ms_bus_r.csr;
  assign o_ms_to_ws_bus.csr_wen   = ms_bus_r.csr_wen;
  assign o_ms_to_ws_bus.csr_wdata = ms_bus_r.csr_result;
  assign o_ms_to_ws_bus.ebreak    = ms_bus_r.ebreak;
  assign o_ms_to_ws_bus.invalid   = ms_bus_r.invalid;

endmodule

/* hw/data_sram.sv */
// byte-masked data memory of 64-bit words with registered read
`include "ex_config.svh"

module data_sram (
  input  logic                   i_clk,
  input  ex_pkg::sram_req_t      i_req,
  output logic [`EX_WORD_WD-1:0] o_rdata
);

  localparam int IDX_WD = $clog2(`EX_SRAM_DEPTH);
  localparam int OFF_WD = $clog2(`EX_SRAM_WMASK_WD);   // byte offset in a word

  logic [`EX_WORD_WD-1:0] mem [`EX_SRAM_DEPTH];
  logic [IDX_WD-1:0]      idx;

  assign idx = i_req.addr[OFF_WD +: IDX_WD];   // addr[10:3]

  // contents start at zero
  initial begin
    for (int i = 0; i < `EX_SRAM_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_req.wen) begin
      for (int b = 0; b < `EX_SRAM_WMASK_WD; b++) begin
        if (i_req.wmask[b]) begin
          mem[idx][b*8 +: 8] <= i_req.wdata[b*8 +: 8];
        end
      end
    end
  end

  // old word on a same-cycle write, rdata held until the next read
  always_ff @(posedge i_clk) begin
    if (i_req.ren) begin
      o_rdata <= mem[idx];
    end
  end

endmodule

/* hw/ex_mem_top.sv */
// top level: execute stage, memory stage and data sram
`include "ex_config.svh"

module ex_mem_top (
  input  logic                  i_clk,
  input  logic                  i_reset,
  input  logic                  i_ds_to_es_valid,
  input  ex_pkg::ds_to_es_bus_t i_ds_to_es_bus,
  output logic                  o_es_allowin,
  input  logic                  i_ws_allowin,
  output logic                  o_ms_to_ws_valid,
  output ex_pkg::ms_to_ws_bus_t o_ms_to_ws_bus
);

  logic                   ms_allowin;
  logic                   es_to_ms_valid;
  ex_pkg::es_to_ms_bus_t  es_to_ms_bus;
  ex_pkg::sram_req_t      sram_req;
  logic [`EX_WORD_WD-1:0] sram_rdata;

  ex_stage u_ex_stage (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_ms_allowin     (ms_allowin),
    .o_es_allowin     (o_es_allowin),
    .i_ds_to_es_valid (i_ds_to_es_valid),
    .i_ds_to_es_bus   (i_ds_to_es_bus),
    .o_es_to_ms_valid (es_to_ms_valid),
    .o_es_to_ms_bus   (es_to_ms_bus),
    .o_sram_req       (sram_req)
  );

  data_sram u_data_sram (
    .i_clk   (i_clk),
    .i_req   (sram_req),
    .o_rdata (sram_rdata)   // one cycle after the request
  );

  mem_stage u_mem_stage (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_es_to_ms_valid (es_to_ms_valid),
    .i_es_to_ms_bus   (es_to_ms_bus),
    .o_ms_allowin     (ms_allowin),
    .i_sram_rdata     (sram_rdata),
    .i_ws_allowin     (i_ws_allowin),
    .o_ms_to_ws_valid (o_ms_to_ws_valid),
    .o_ms_to_ws_bus   (o_ms_to_ws_bus)
  );

endmodule

/* tb/tb_ex_mem.sv */
// testbench for ex_mem_top with random stimulus, reference model, scoreboard and watchdog
`include "ex_config.svh"

module tb_ex_mem;

  localparam int CLK_PERIOD = 20;
  localparam int N_RANDOM   = 400;   // random valid and back-pressure
  localparam int N_TOTAL    = 500;   // then steady stream with i_ws_allowin high
  localparam int MEM_BYTES  = `EX_SRAM_DEPTH * 8;
  localparam int WATCHDOG_CYCLES = 200 * N_TOTAL + 3;

  logic                  i_clk;
  logic                  i_reset;
  logic                  i_ds_to_es_valid;
  ex_pkg::ds_to_es_bus_t i_ds_to_es_bus;
  logic                  o_es_allowin;
  logic                  i_ws_allowin;
  logic                  o_ms_to_ws_valid;
  ex_pkg::ms_to_ws_bus_t o_ms_to_ws_bus;

  logic [31:0] lfsr_state = 32'h6ec3_1ba0;
  logic [7:0]  mem_model [MEM_BYTES];
  logic        steady;
  int          errors = 0;
  int          outputs = 0;
  int          cycle = 0;
  int          stall_cycles = 0;
  int          sram_writes = 0;
  int          sram_reads = 0;
  int          exp_writes = 0;
  int          exp_reads = 0;

  ex_pkg::ms_to_ws_bus_t exp_q[$];
  int                    cyc_q[$];
  logic                  steady_q[$];

  ex_mem_top dut0 (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_ds_to_es_valid (i_ds_to_es_valid),
    .i_ds_to_es_bus   (i_ds_to_es_bus),
    .o_es_allowin     (o_es_allowin),
    .i_ws_allowin     (i_ws_allowin),
    .o_ms_to_ws_valid (o_ms_to_ws_valid),
    .o_ms_to_ws_bus   (o_ms_to_ws_bus)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  // fibonacci lfsr with taps 32 22 2 1 and one step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      r = {r[62:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic ex_pkg::ds_to_es_bus_t new_bundle();
    ex_pkg::ds_to_es_bus_t b;
    logic [1:0]  kind;
    logic [2:0]  op3;
    logic [10:0] addr;
    logic [11:0] offs;
    b = '0;
    b.rs1data          = rand_bits(64);
    b.rs2data          = rand_bits(64);
    b.csrrdata         = rand_bits(64);
    b.imm              = rand_bits(64);
    b.pc               = rand_bits(64) & 64'hffff_ffff_ffff_fffc;
    b.rd               = 5'(rand_bits(5));
    b.csr              = 12'(rand_bits(12));
    b.ebreak_sel       = 1'(rand_bits(1));
    b.invalid_inst_sel = 1'(rand_bits(1));
    op3 = 3'(rand_bits(3));
    if (op3[1:0] == 2'b00) op3[1:0] = 2'b01;   // only legal csr ops
    b.csr_op = ex_pkg::csr_op_e'(op3);
    kind = 2'(rand_bits(2));
    if (kind == 2'd0) begin
      b.alu_src1_sel     = 1'(rand_bits(1));
      b.alu_src2_sel     = ex_pkg::alu_src2_e'(2'(rand_bits(2) % 3));
      b.alu_op           = ex_pkg::alu_op_e'(5'(rand_bits(4) % 11));
      b.alu_word_cut_sel = 1'(rand_bits(1));
      b.gpr_wen          = 1'b1;
    end else if (kind == 2'd1) begin
      b.csr_inst_sel = 1'b1;
      b.csr_wen      = 1'b1;
      b.gpr_wen      = 1'b1;
      if (op3[2]) b.imm = {59'b0, 5'(rand_bits(5))};   // zimm
    end else begin
      op3 = 3'(rand_bits(3));
      if (kind == 2'd2) op3[2] = 1'b0;
      if (op3 == 3'b111) op3 = 3'b011;
      addr = 11'(rand_bits(11));
      addr = addr & ~((11'd1 << op3[1:0]) - 11'd1);   // size aligned
      offs = 12'(rand_bits(12));
      b.imm          = {{52{offs[11]}}, offs};
      b.rs1data      = {53'b0, addr} - b.imm;
      b.alu_src2_sel = ex_pkg::SRC2_IMM;
      b.alu_op       = ex_pkg::ALU_ADD;
      b.mem_op       = ex_pkg::mem_op_e'(op3);
      b.mem_wen      = (kind == 2'd2);
      b.mem_ren      = (kind == 2'd3);
      b.gpr_wen      = (kind == 2'd3);
    end
    return b;
  endfunction

  function automatic logic [63:0] alu_model(input ex_pkg::ds_to_es_bus_t b);
    logic [63:0] a;
    logic [63:0] c;
    logic [63:0] r;
    logic [31:0] w;
    a = b.alu_src1_sel ? b.pc : b.rs1data;
    case (b.alu_src2_sel)
      ex_pkg::SRC2_IMM:  c = b.imm;
      ex_pkg::SRC2_FOUR: c = 64'd4;
      default:           c = b.rs2data;
    endcase
    case (b.alu_op)
      ex_pkg::ALU_ADD:  r = a + c;
      ex_pkg::ALU_SUB:  r = a - c;
      ex_pkg::ALU_SLL:  r = a << c[5:0];
      ex_pkg::ALU_SLT:  r = ($signed(a) < $signed(c)) ? 64'd1 : 64'd0;
      ex_pkg::ALU_SLTU: r = (a < c) ? 64'd1 : 64'd0;
      ex_pkg::ALU_XOR:  r = a ^ c;
      ex_pkg::ALU_SRL:  r = a >> c[5:0];
      ex_pkg::ALU_SRA:  r = $signed(a) >>> c[5:0];
      ex_pkg::ALU_OR:   r = a | c;
      ex_pkg::ALU_AND:  r = a & c;
      default:          r = c;
    endcase
    if (b.alu_word_cut_sel) begin
      w = a[31:0];
      case (b.alu_op)
        ex_pkg::ALU_SLL: w = w << c[4:0];
        ex_pkg::ALU_SRL: w = w >> c[4:0];
        ex_pkg::ALU_SRA: w = $signed(w) >>> c[4:0];
        default:         w = r[31:0];
      endcase
      r = {{32{w[31]}}, w};
    end
    return r;
  endfunction

  function automatic logic [63:0] csr_model(input ex_pkg::ds_to_es_bus_t b);
    logic [2:0]  f3;
    logic [63:0] s;
    f3 = b.csr_op;
    s  = f3[2] ? b.imm : b.rs1data;
    case (f3[1:0])
      2'b01:   return s;
      2'b10:   return b.csrrdata | s;
      default: return b.csrrdata & ~s;
    endcase
  endfunction

  function automatic logic [63:0] load_model(input logic [10:0] addr, input logic [2:0] op);
    logic [63:0] v;
    int          nbytes;
    v = '0;
    nbytes = 1 << op[1:0];
    for (int i = 0; i < nbytes; i++) v[i*8 +: 8] = mem_model[addr + 11'(i)];
    if (!op[2]) begin
      for (int i = nbytes * 8; i < 64; i++) v[i] = v[nbytes*8-1];   // sign extend
    end
    return v;
  endfunction

  task automatic store_model(input logic [10:0] addr, input logic [2:0] op,
                             input logic [63:0] data);
    for (int i = 0; i < (1 << op[1:0]); i++) mem_model[addr + 11'(i)] = data[i*8 +: 8];
  endtask

  function automatic ex_pkg::ms_to_ws_bus_t expected_result(input ex_pkg::ds_to_es_bus_t b);
    ex_pkg::ms_to_ws_bus_t e;
    logic [63:0]           alu;
    alu = alu_model(b);
    e.pc        = b.pc;
    e.rd        = b.rd;
    e.gpr_wen   = b.gpr_wen;
    e.csr       = b.csr;
    e.csr_wen   = b.csr_wen;
    e.csr_wdata = csr_model(b);
    e.ebreak    = b.ebreak_sel;
    e.invalid   = b.invalid_inst_sel;
    if (b.mem_ren) e.gpr_wdata = load_model(alu[10:0], b.mem_op);
    else if (b.csr_inst_sel) e.gpr_wdata = b.csrrdata;
    else e.gpr_wdata = alu;
    return e;
  endfunction

  // all values sampled here are the ones before the edge
  always @(posedge i_clk) begin : scoreboard
    ex_pkg::ms_to_ws_bus_t expd;
    logic                  exp_allowin;
    logic                  stdy;
    int                    cyc;
    logic [63:0]           store_alu;
    if (!i_reset) begin
      exp_allowin = (exp_q.size() < 2) || i_ws_allowin;
      if (o_es_allowin !== exp_allowin) begin
        errors++;
        $display("Mismatch es_allowin: expected %b, actual %b", exp_allowin, o_es_allowin);
      end
      if (!o_es_allowin) stall_cycles++;
      if (dut0.sram_req.wen) sram_writes++;
      if (dut0.sram_req.ren) sram_reads++;
      if (o_ms_to_ws_valid && i_ws_allowin) begin
        outputs++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("output transfer at cycle %0d with no instruction outstanding", cycle);
        end else begin
          expd = exp_q.pop_front();
          cyc  = cyc_q.pop_front();
          stdy = steady_q.pop_front();
          if (o_ms_to_ws_bus !== expd) begin
            errors++;
            $display("Mismatch wb_bus pc=%h: expected %h, actual %h",
                     expd.pc, expd, o_ms_to_ws_bus);
          end
          if (stdy && (cycle - cyc) != 2) begin
            errors++;
            $display("Mismatch latency pc=%h: expected 2, actual %0d", expd.pc, cycle - cyc);
          end
        end
      end
      if (i_ds_to_es_valid && o_es_allowin) begin
        exp_q.push_back(expected_result(i_ds_to_es_bus));
        cyc_q.push_back(cycle);
        steady_q.push_back(steady);
        if (i_ds_to_es_bus.mem_ren) exp_reads++;
        if (i_ds_to_es_bus.mem_wen) begin
          exp_writes++;
          store_alu = alu_model(i_ds_to_es_bus);
          store_model(store_alu[10:0], i_ds_to_es_bus.mem_op, i_ds_to_es_bus.rs2data);
        end
      end
    end
    cycle++;
  end

  initial begin : stimulus
    int   accepted;
    logic fired;
    for (int i = 0; i < MEM_BYTES; i++) mem_model[i] = 8'h00;
    i_reset          <= 1'b1;
    i_ds_to_es_valid <= 1'b0;
    i_ds_to_es_bus   <= '0;
    i_ws_allowin     <= 1'b0;
    steady           <= 1'b0;
    repeat (3) @(posedge i_clk);
    i_reset <= 1'b0;
    @(posedge i_clk);
    if (o_es_allowin !== 1'b1) begin
      errors++;
      $display("Mismatch reset_allowin: expected 1, actual %b", o_es_allowin);
    end
    if (o_ms_to_ws_valid !== 1'b0) begin
      errors++;
      $display("Mismatch reset_valid: expected 0, actual %b", o_ms_to_ws_valid);
    end
    accepted = 0;
    i_ds_to_es_bus   <= new_bundle();
    i_ds_to_es_valid <= 1'b1;
    i_ws_allowin     <= 1'b1;
    while (accepted < N_TOTAL) begin
      @(posedge i_clk);
      fired = i_ds_to_es_valid && o_es_allowin;
      if (fired) begin
        accepted++;
        i_ds_to_es_bus <= new_bundle();   // bundle only moves on after its transfer
      end
      if (accepted >= N_RANDOM) begin
        steady           <= 1'b1;
        i_ws_allowin     <= 1'b1;
        i_ds_to_es_valid <= (accepted < N_TOTAL);
      end else begin
        i_ws_allowin <= 1'(rand_bits(1));
        if (fired || !i_ds_to_es_valid) i_ds_to_es_valid <= (rand_bits(2) != 64'd0);
      end
    end
    while (exp_q.size() != 0) @(negedge i_clk);
    repeat (2) @(negedge i_clk);
    if (sram_writes != exp_writes) begin
      errors++;
      $display("Mismatch sram_writes: expected %0d, actual %0d", exp_writes, sram_writes);
    end
    if (sram_reads != exp_reads) begin
      errors++;
      $display("Mismatch sram_reads: expected %0d, actual %0d", exp_reads, sram_reads);
    end
    if (stall_cycles == 0) begin
      errors++;
      $display("o_es_allowin never went low under back-pressure");
    end
    $display("%0d instructions, %0d outputs, %0d stall cycles, %0d errors",
             N_TOTAL, outputs, stall_cycles, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout after %0d cycles, pipeline did not drain", WATCHDOG_CYCLES);
    $display("TB FAILED");
    $finish;
  end

endmodule

/* files.f */
+incdir+common
common/ex_pkg.sv
ex/exu.sv
ex/lsu_store.sv
ex/ex_stage.sv
mem/mem_stage.sv
hw/data_sram.sv
hw/ex_mem_top.sv
tb/tb_ex_mem.sv

/* run_sim.sh */
#!/bin/sh
# builds the execute/memory testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 -f files.f --top-module tb_ex_mem -Mdir obj_dir

out=$(./obj_dir/Vtb_ex_mem)
echo "$out"

# exit status follows the pass line
echo "$out" | grep -q "^TB PASSED$"
